// ==== project.f ====
efpga_pkg.sv
lint_bus_fsm.sv
read_delay_timer.sv
pad_event_regs.sv
tcdm_port.sv
efpga_test_top.sv
efpga_test_properties.sv
efpga_test_tb.sv

// ==== Makefile ====
# Verilator simulation of the efpga register-bus test block

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f project.f --top-module efpga_test_tb -o sim

# the testbench polls the bound assertions, so keep running past an $error
run: compile
	./obj_dir/sim +verilator+error+limit+100 | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== efpga_test_tb.sv ====
/*
  efpga test block testbench
  clock and reset, register bus driver, TCDM memory model and scoreboard
*/
`default_nettype none

module efpga_test_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IO_WIDTH   = 80;
  localparam int MAX_CYCLES = 4000; // many times the length of the traffic

  logic                          CLK;
  logic                          rst_n;
  logic                          lint_req;
  logic                          lint_wen;
  efpga_pkg::bus_addr_t          lint_addr;
  efpga_pkg::bus_data_t          lint_wdata;
  efpga_pkg::be_t                lint_be;
  logic                          lint_gnt;
  logic                          lint_valid;
  efpga_pkg::bus_data_t          lint_rdata;
  logic [IO_WIDTH-1:0]           fpgaio_in;
  logic [IO_WIDTH-1:0]           fpgaio_out;
  logic [IO_WIDTH-1:0]           fpgaio_oe;
  logic [efpga_pkg::EVENT_W-1:0] events_o;
  logic                          tcdm_gnt;
  logic                          tcdm_fmo;
  logic                          tcdm_valid;
  efpga_pkg::bus_data_t          tcdm_rdata;
  logic                          tcdm_req;
  logic                          tcdm_wen;
  efpga_pkg::tcdm_addr_t         tcdm_addr;
  efpga_pkg::be_t                tcdm_be;
  efpga_pkg::bus_data_t          tcdm_wdata;
  int                            cycles = 0;

  efpga_test_top #(
    .IO_WIDTH (IO_WIDTH)
  ) i_efpga_test_top (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .lint_req   (lint_req),
    .lint_wen   (lint_wen),
    .lint_addr  (lint_addr),
    .lint_wdata (lint_wdata),
    .lint_be    (lint_be),
    .lint_gnt   (lint_gnt),
    .lint_valid (lint_valid),
    .lint_rdata (lint_rdata),
    .fpgaio_in  (fpgaio_in),
    .fpgaio_out (fpgaio_out),
    .fpgaio_oe  (fpgaio_oe),
    .events_o   (events_o),
    .tcdm_gnt   (tcdm_gnt),
    .tcdm_fmo   (tcdm_fmo),
    .tcdm_valid (tcdm_valid),
    .tcdm_rdata (tcdm_rdata),
    .tcdm_req   (tcdm_req),
    .tcdm_wen   (tcdm_wen),
    .tcdm_addr  (tcdm_addr),
    .tcdm_be    (tcdm_be),
    .tcdm_wdata (tcdm_wdata)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input bit ok, input string what);
    assert (ok) else stop_with_failure($sformatf("Mismatch at %0d ns: %s", $time, what));
  endtask

  // grant delay counted in edges from raising lint_req
  function automatic int read_latency(input efpga_pkg::bus_addr_t addr);
    return (addr[19:8] == 12'h009) ? 3 + int'(addr[7:0]) : 3;
  endfunction

  task automatic bus_write(input efpga_pkg::bus_addr_t addr, input efpga_pkg::bus_data_t data,
                           input int hold);
    int n;
    n          = 0;
    lint_addr  = addr;
    lint_wdata = data;
    lint_wen   = 1'b0;
    lint_be    = 4'hF;
    lint_req   = 1'b1;
    do begin
      @(posedge CLK);
      #1;
      n++;
    end while (!lint_gnt);
    check_value(n == 1, $sformatf("write 0x%05h granted after %0d cycles, want 1", addr, n));
    @(posedge CLK);
    #1;
    check_value(lint_valid && !lint_gnt, $sformatf("write 0x%05h valid not at cycle 2", addr));
    repeat (hold) begin // held request must not start another access
      @(posedge CLK);
      #1;
      check_value(!lint_gnt && !lint_valid, "held request started a second access");
    end
    lint_req = 1'b0;
    @(posedge CLK);
    #1;
  endtask

  task automatic bus_read(input efpga_pkg::bus_addr_t addr, input efpga_pkg::bus_data_t expected);
    int n;
    n         = 0;
    lint_addr = addr;
    lint_wen  = 1'b1;
    lint_req  = 1'b1;
    do begin
      @(posedge CLK);
      #1;
      n++;
    end while (!lint_gnt);
    check_value(n == read_latency(addr), $sformatf("read 0x%05h granted after %0d cycles, want %0d",
                                                   addr, n, read_latency(addr)));
    @(posedge CLK);
    #1;
    check_value(lint_valid, $sformatf("read 0x%05h valid missing after grant", addr));
    check_value(lint_rdata == expected, $sformatf("read 0x%05h got 0x%08h, want 0x%08h",
                                                  addr, lint_rdata, expected));
    lint_req = 1'b0;
    @(posedge CLK);
    #1;
  endtask

  // TCDM memory model that always misses the first grant of a request
  initial begin : tcdm_model
    bit fmo;
    bit fmo_given;
    fmo_given  = 1'b0;
    tcdm_gnt   = 1'b0;
    tcdm_fmo   = 1'b0;
    tcdm_valid = 1'b0;
    tcdm_rdata = '0;
    forever begin
      @(posedge CLK);
      #1;
      if (tcdm_req) begin
        repeat ($urandom_range(3)) begin
          @(posedge CLK);
          #1;
        end
        fmo       = !fmo_given || ($urandom_range(3) == 0);
        fmo_given = fmo;
        tcdm_gnt  = 1'b1;
        tcdm_fmo  = fmo;
        @(posedge CLK);
        #1;
        tcdm_gnt = 1'b0;
        tcdm_fmo = 1'b0;
        if (!fmo) begin
          tcdm_valid = 1'b1;
          tcdm_rdata = ~{12'h000, tcdm_addr}; // memory returns inverted address
          @(posedge CLK);
          #1;
          tcdm_valid = 1'b0;
        end
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (i_efpga_test_top.i_efpga_test_properties.fail_count != 0)
      stop_with_failure("a bound bus or TCDM protocol assertion failed");
    else if (cycles >= MAX_CYCLES)
      stop_with_failure("timeout: the tests did not finish within the cycle limit");
  end

  initial begin : stimulus
    logic [95:0]          out_model;
    logic [95:0]          oe_model;
    logic [95:0]          rnd;
    efpga_pkg::bus_data_t w;
    efpga_pkg::bus_data_t cfg;
    efpga_pkg::bus_addr_t a;
    lint_req   = 1'b0;
    lint_wen   = 1'b1;
    lint_addr  = '0;
    lint_wdata = '0;
    lint_be    = '0;
    fpgaio_in  = '0;
    rst_n      = 1'b0;
    out_model  = '0;
    oe_model   = '0;
    void'($urandom(18713));
    repeat (16) @(posedge CLK);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < 3; i++) begin // pad output and enable words
      w = $urandom();
      out_model[i*32 +: 32] = w;
      out_model[95:IO_WIDTH] = '0;
      bus_write(efpga_pkg::bus_addr_t'(efpga_pkg::REG_PAD_OUT0 + 4 * i), w, 0);
      check_value(fpgaio_out == out_model[IO_WIDTH-1:0], $sformatf("fpgaio_out word %0d", i));
      w = $urandom();
      oe_model[i*32 +: 32] = w;
      oe_model[95:IO_WIDTH] = '0;
      bus_write(efpga_pkg::bus_addr_t'(efpga_pkg::REG_PAD_OE0 + 4 * i), w, 0);
      check_value(fpgaio_oe == oe_model[IO_WIDTH-1:0], $sformatf("fpgaio_oe word %0d", i));
    end
    for (int i = 0; i < 3; i++) begin
      bus_read(efpga_pkg::bus_addr_t'(efpga_pkg::REG_PAD_OUT0 + 4 * i), out_model[i*32 +: 32]);
      bus_read(efpga_pkg::bus_addr_t'(efpga_pkg::REG_PAD_OE0 + 4 * i), oe_model[i*32 +: 32]);
    end
    w = $urandom();
    bus_write(efpga_pkg::REG_EVENTS, w, 0);
    check_value(events_o == w[15:0], "events_o after event write");
    bus_read(efpga_pkg::REG_EVENTS, {16'h0000, w[15:0]});

    rnd = {$urandom(), $urandom(), $urandom()};
    rnd[95:IO_WIDTH] = '0;
    fpgaio_in = rnd[IO_WIDTH-1:0];
    for (int i = 0; i < 3; i++)
      bus_read(efpga_pkg::bus_addr_t'(efpga_pkg::REG_PAD_IN0 + 4 * i), rnd[i*32 +: 32]);
    bus_read(efpga_pkg::REG_ID, 32'hCA11EF3A);
    bus_read(20'h00100, 32'h0); // unmapped

    for (int k = 0; k < 3; k++) begin // TCDM config, trigger and result
      w   = $urandom();
      cfg = {1'(k), 7'h7F, w[23:0]}; // bits 30:24 are not stored
      bus_write(efpga_pkg::REG_TCDM_CFG, cfg, 0);
      check_value(tcdm_addr == cfg[19:0] && tcdm_wen == cfg[31] && tcdm_be == ~cfg[23:20],
                  "TCDM address, write enable or byte enables");
      bus_read(efpga_pkg::REG_TCDM_CFG, {cfg[31], 7'h00, cfg[23:0]});
      w = $urandom();
      bus_write(efpga_pkg::REG_TCDM_DATA, w, 0);
      check_value(tcdm_req && tcdm_wdata == w, "TCDM request or write data after trigger");
      while (tcdm_req) begin
        @(posedge CLK);
        #1;
      end
      repeat (2) @(posedge CLK);
      #1;
      bus_read(efpga_pkg::REG_TCDM_DATA, ~{12'h000, cfg[19:0]});
    end

    for (int k = 0; k < 3; k++) begin // delay window reads
      a = {12'h009, (k == 0) ? 8'd0 : ((k == 1) ? 8'd5 : 8'(1 + $urandom_range(39)))};
      bus_read(a, {12'h000, a});
    end

    w = $urandom();
    bus_write(efpga_pkg::REG_EVENTS, w, 6);
    check_value(events_o == w[15:0], "events_o after held write");

    repeat (4) @(posedge CLK);
    #1;
    if (i_efpga_test_top.i_efpga_test_properties.fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_with_failure("a bound bus or TCDM protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

// ==== efpga_test_properties.sv ====
/*
  bus and TCDM protocol checks
  bound into the test block top level
*/
`default_nettype none

module efpga_test_properties (
  input logic CLK,
  input logic rst_n,
  input logic lint_gnt,
  input logic lint_valid,
  input logic tcdm_req,
  input logic tcdm_gnt,
  input logic tcdm_fmo
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0; // polled by the testbench

  gnt_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
    lint_gnt |=> !lint_gnt)
    else begin
      fail_count++;
      $error("lint_gnt high for more than one cycle");
    end

  valid_after_gnt: assert property (@(posedge CLK) disable iff (!rst_n)
    lint_gnt |=> lint_valid)
    else begin
      fail_count++;
      $error("lint_valid missing one cycle after lint_gnt");
    end

  valid_only_after_gnt: assert property (@(posedge CLK) disable iff (!rst_n)
    !lint_gnt |=> !lint_valid)
    else begin
      fail_count++;
      $error("lint_valid without lint_gnt one cycle before");
    end

  // an fmo grant does not end the request
  req_held: assert property (@(posedge CLK) disable iff (!rst_n)
    (tcdm_req && !(tcdm_gnt && !tcdm_fmo)) |=> tcdm_req)
    else begin
      fail_count++;
      $error("tcdm_req dropped before a clean grant");
    end

  reset_low: assert property (@(posedge CLK)
    !rst_n |=> (!lint_gnt && !lint_valid && !tcdm_req))
    else begin
      fail_count++;
      $error("grant, valid or request high after reset");
    end

endmodule

bind efpga_test_top efpga_test_properties i_efpga_test_properties (
  .CLK        (CLK),
  .rst_n      (rst_n),
  .lint_gnt   (lint_gnt),
  .lint_valid (lint_valid),
  .tcdm_req   (tcdm_req),
  .tcdm_gnt   (tcdm_gnt),
  .tcdm_fmo   (tcdm_fmo)
);

`default_nettype wire

// ==== efpga_test_top.sv ====
/*
  efpga register-bus test block, top level
  connects bus FSM, read delay timer, pad/event registers and TCDM port
*/
`default_nettype none

module efpga_test_top #(
  parameter int IO_WIDTH = 80
) (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          lint_req,
  input  logic                          lint_wen,
  input  efpga_pkg::bus_addr_t          lint_addr,
  input  efpga_pkg::bus_data_t          lint_wdata,
  input  efpga_pkg::be_t                lint_be, // all kept registers take full words
  output logic                          lint_gnt,
  output logic                          lint_valid,
  output efpga_pkg::bus_data_t          lint_rdata,
  input  logic [IO_WIDTH-1:0]           fpgaio_in,
  output logic [IO_WIDTH-1:0]           fpgaio_out,
  output logic [IO_WIDTH-1:0]           fpgaio_oe,
  output logic [efpga_pkg::EVENT_W-1:0] events_o,
  input  logic                          tcdm_gnt,
  input  logic                          tcdm_fmo,
  input  logic                          tcdm_valid,
  input  efpga_pkg::bus_data_t          tcdm_rdata,
  output logic                          tcdm_req,
  output logic                          tcdm_wen,
  output efpga_pkg::tcdm_addr_t         tcdm_addr,
  output efpga_pkg::be_t                tcdm_be,
  output efpga_pkg::bus_data_t          tcdm_wdata
);

  logic                 wr_stb;
  logic                 rd_stb;
  logic                 delay_done;
  efpga_pkg::bus_data_t tcdm_cfg_word;
  efpga_pkg::bus_data_t tcdm_result;

  lint_bus_fsm i_lint_bus_fsm (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .lint_req   (lint_req),
    .lint_wen   (lint_wen),
    .delay_done (delay_done),
    .lint_gnt   (lint_gnt),
    .lint_valid (lint_valid),
    .wr_stb     (wr_stb),
    .rd_stb     (rd_stb)
  );

  read_delay_timer i_read_delay_timer (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .rd_stb     (rd_stb),
    .lint_addr  (lint_addr),
    .delay_done (delay_done)
  );

  pad_event_regs #(
    .IO_WIDTH (IO_WIDTH)
  ) i_pad_event_regs (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .wr_stb        (wr_stb),
    .rd_stb        (rd_stb),
    .lint_addr     (lint_addr),
    .lint_wdata    (lint_wdata),
    .fpgaio_in     (fpgaio_in),
    .tcdm_cfg_word (tcdm_cfg_word),
    .tcdm_result   (tcdm_result),
    .fpgaio_out    (fpgaio_out),
    .fpgaio_oe     (fpgaio_oe),
    .events_o      (events_o),
    .lint_rdata    (lint_rdata)
  );

  tcdm_port i_tcdm_port (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .wr_stb        (wr_stb),
    .lint_addr     (lint_addr),
    .lint_wdata    (lint_wdata),
    .tcdm_gnt      (tcdm_gnt),
    .tcdm_fmo      (tcdm_fmo),
    .tcdm_valid    (tcdm_valid),
    .tcdm_rdata    (tcdm_rdata),
    .tcdm_req      (tcdm_req),
    .tcdm_addr     (tcdm_addr),
    .tcdm_wen      (tcdm_wen),
    .tcdm_be       (tcdm_be),
    .tcdm_wdata    (tcdm_wdata),
    .tcdm_cfg_word (tcdm_cfg_word),
    .tcdm_result   (tcdm_result)
  );

endmodule

`default_nettype wire

// ==== tcdm_port.sv ====
/*
  single-word TCDM master
  configuration register, request held until a clean grant, result capture
*/
`default_nettype none

module tcdm_port (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  wr_stb,
  input  efpga_pkg::bus_addr_t  lint_addr,
  input  efpga_pkg::bus_data_t  lint_wdata,
  input  logic                  tcdm_gnt,
  input  logic                  tcdm_fmo,
  input  logic                  tcdm_valid,
  input  efpga_pkg::bus_data_t  tcdm_rdata,
  output logic                  tcdm_req,
  output efpga_pkg::tcdm_addr_t tcdm_addr,
  output logic                  tcdm_wen,
  output efpga_pkg::be_t        tcdm_be,
  output efpga_pkg::bus_data_t  tcdm_wdata,
  output efpga_pkg::bus_data_t  tcdm_cfg_word,
  output efpga_pkg::bus_data_t  tcdm_result
);

  logic cfg_wr;
  logic data_wr;

  assign cfg_wr  = wr_stb & (lint_addr == efpga_pkg::REG_TCDM_CFG);
  assign data_wr = wr_stb & (lint_addr == efpga_pkg::REG_TCDM_DATA);

  // same layout the host writes
  assign tcdm_cfg_word = {tcdm_wen, 7'b0, ~tcdm_be, tcdm_addr};

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tcdm_addr <= '0;
      tcdm_wen  <= 1'b0;
      tcdm_be   <= '0;
    end else if (cfg_wr) begin
      tcdm_addr <= lint_wdata[19:0];
      tcdm_wen  <= lint_wdata[31];
      tcdm_be   <= ~lint_wdata[23:20]; // stored inverted
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tcdm_req   <= 1'b0;
      tcdm_wdata <= '0;
    end else begin
      if (tcdm_gnt & ~tcdm_fmo)
        tcdm_req <= 1'b0; // fmo grant keeps the request up
      if (data_wr) begin
        tcdm_wdata <= lint_wdata;
        tcdm_req   <= 1'b1; // new trigger wins
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n)
      tcdm_result <= '0;
    else if (tcdm_valid)
      tcdm_result <= tcdm_rdata;
  end

endmodule

`default_nettype wire

// ==== pad_event_regs.sv ====
/*
  pad and event registers
  pad output / output-enable and event registers, plus the read-back
  multiplexer feeding the registered bus read data
*/
`default_nettype none

module pad_event_regs #(
  parameter int IO_WIDTH = 80
) (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          wr_stb,
  input  logic                          rd_stb,
  input  efpga_pkg::bus_addr_t          lint_addr,
  input  efpga_pkg::bus_data_t          lint_wdata,
  input  logic [IO_WIDTH-1:0]           fpgaio_in,
  input  efpga_pkg::bus_data_t          tcdm_cfg_word,
  input  efpga_pkg::bus_data_t          tcdm_result,
  output logic [IO_WIDTH-1:0]           fpgaio_out,
  output logic [IO_WIDTH-1:0]           fpgaio_oe,
  output logic [efpga_pkg::EVENT_W-1:0] events_o,
  output efpga_pkg::bus_data_t          lint_rdata
);

  localparam int PAD_EXT_W = 96; // three bus words of pads

  logic [PAD_EXT_W-1:0] out_ext, oe_ext, in_ext;
  efpga_pkg::bus_data_t rd_mux;

  // pads zero-extended to three words
  assign out_ext = PAD_EXT_W'(fpgaio_out);
  assign oe_ext  = PAD_EXT_W'(fpgaio_oe);
  assign in_ext  = PAD_EXT_W'(fpgaio_in);

  function automatic logic [IO_WIDTH-1:0] put_word(input logic [PAD_EXT_W-1:0] cur,
                                                   input int unsigned idx,
                                                   input efpga_pkg::bus_data_t w);
    logic [PAD_EXT_W-1:0] tmp;
    tmp = cur;
    tmp[idx*32 +: 32] = w;
    return tmp[IO_WIDTH-1:0]; // bits beyond the pad count drop off
  endfunction

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      fpgaio_out <= '0;
      fpgaio_oe  <= '0;
      events_o   <= '0;
    end else if (wr_stb) begin
      case (lint_addr)
        efpga_pkg::REG_PAD_OUT0: fpgaio_out <= put_word(out_ext, 0, lint_wdata);
        efpga_pkg::REG_PAD_OUT1: fpgaio_out <= put_word(out_ext, 1, lint_wdata);
        efpga_pkg::REG_PAD_OUT2: fpgaio_out <= put_word(out_ext, 2, lint_wdata);
        efpga_pkg::REG_PAD_OE0:  fpgaio_oe  <= put_word(oe_ext, 0, lint_wdata);
        efpga_pkg::REG_PAD_OE1:  fpgaio_oe  <= put_word(oe_ext, 1, lint_wdata);
        efpga_pkg::REG_PAD_OE2:  fpgaio_oe  <= put_word(oe_ext, 2, lint_wdata);
        efpga_pkg::REG_EVENTS:   events_o   <= lint_wdata[efpga_pkg::EVENT_W-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (lint_addr)
      efpga_pkg::REG_TCDM_CFG:  rd_mux = tcdm_cfg_word;
      efpga_pkg::REG_PAD_OUT0:  rd_mux = out_ext[31:0];
      efpga_pkg::REG_PAD_OUT1:  rd_mux = out_ext[63:32];
      efpga_pkg::REG_PAD_OUT2:  rd_mux = out_ext[95:64];
      efpga_pkg::REG_PAD_OE0:   rd_mux = oe_ext[31:0];
      efpga_pkg::REG_PAD_OE1:   rd_mux = oe_ext[63:32];
      efpga_pkg::REG_PAD_OE2:   rd_mux = oe_ext[95:64];
      efpga_pkg::REG_PAD_IN0:   rd_mux = in_ext[31:0];
      efpga_pkg::REG_PAD_IN1:   rd_mux = in_ext[63:32];
      efpga_pkg::REG_PAD_IN2:   rd_mux = in_ext[95:64];
      efpga_pkg::REG_EVENTS:    rd_mux = 32'(events_o);
      efpga_pkg::REG_TCDM_DATA: rd_mux = tcdm_result;
      efpga_pkg::REG_ID:        rd_mux = efpga_pkg::ID_VALUE;
      default: begin
        if (lint_addr[19:8] == efpga_pkg::DELAY_REGION)
          rd_mux = {12'h000, lint_addr}; // echo of the window address
        else
          rd_mux = '0;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rst_n)
      lint_rdata <= '0;
    else if (rd_stb)
      lint_rdata <= rd_mux;
  end

endmodule

`default_nettype wire

// ==== read_delay_timer.sv ====
/*
  read delay timer
  stretches reads in the 0x9XX window by the address low byte
*/
`default_nettype none

module read_delay_timer (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 rd_stb,
  input  efpga_pkg::bus_addr_t lint_addr,
  output logic                 delay_done
);

  logic [7:0] count;
  logic       in_window;

  assign in_window  = (lint_addr[19:8] == efpga_pkg::DELAY_REGION);
  assign delay_done = (count == 8'd0);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      count <= 8'd0;
    end else if (rd_stb) begin
      count <= in_window ? lint_addr[7:0] : 8'd0;
    end else if (count != 8'd0) begin
      count <= count - 8'd1;
    end
  end

endmodule

`default_nettype wire

// ==== lint_bus_fsm.sv ====
/*
  register bus slave FSM
  accepts a request on the rising edge of lint_req, sequences grant and
  valid, and issues one-cycle write and read strobes to the data blocks
*/
`default_nettype none

module lint_bus_fsm (
  input  logic CLK,
  input  logic rst_n,
  input  logic lint_req,
  input  logic lint_wen,
  input  logic delay_done,
  output logic lint_gnt,
  output logic lint_valid,
  output logic wr_stb,
  output logic rd_stb
);

  efpga_pkg::bus_state_e state;
  logic                  req_q;
  logic                  req_rise;

  // new request only when not still granting the last one
  assign req_rise = lint_req & ~req_q & ~lint_gnt;

  assign wr_stb = (state == efpga_pkg::BUS_WRITE);
  assign rd_stb = (state == efpga_pkg::BUS_READ);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state      <= efpga_pkg::BUS_IDLE;
      req_q      <= 1'b0;
      lint_gnt   <= 1'b0;
      lint_valid <= 1'b0;
    end else begin
      req_q      <= lint_req;
      lint_valid <= lint_gnt; // valid trails grant by one cycle
      case (state)
        efpga_pkg::BUS_IDLE: begin
          lint_gnt <= 1'b0;
          if (req_rise) begin
            if (!lint_wen) begin // low wen is a write
              lint_gnt <= 1'b1;
              state    <= efpga_pkg::BUS_WRITE;
            end else begin
              state <= efpga_pkg::BUS_READ;
            end
          end
        end
        efpga_pkg::BUS_WRITE: begin
          lint_gnt <= 1'b0; // register updates at this edge
          state    <= efpga_pkg::BUS_IDLE;
        end
        efpga_pkg::BUS_READ: begin
          state <= efpga_pkg::BUS_READ_WAIT; // rdata and delay load here
        end
        efpga_pkg::BUS_READ_WAIT: begin
          if (delay_done) begin
            lint_gnt <= 1'b1;
            state    <= efpga_pkg::BUS_IDLE;
          end
        end
        default: begin
          lint_gnt <= 1'b0;
          state    <= efpga_pkg::BUS_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== efpga_pkg.sv ====
/*
  efpga test block package
  bus widths and types, register map, bus FSM states and fixed values
*/
`default_nettype none

package efpga_pkg;

  localparam int BUS_ADDR_W  = 20;
  localparam int BUS_DATA_W  = 32;
  localparam int TCDM_ADDR_W = 20;
  localparam int BE_W        = 4;
  localparam int EVENT_W     = 16;

  typedef logic [BUS_ADDR_W-1:0]  bus_addr_t;
  typedef logic [BUS_DATA_W-1:0]  bus_data_t;
  typedef logic [TCDM_ADDR_W-1:0] tcdm_addr_t;
  typedef logic [BE_W-1:0]        be_t;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_WRITE,
    BUS_READ,
    BUS_READ_WAIT
  } bus_state_e;

  typedef enum logic [BUS_ADDR_W-1:0] {
    REG_TCDM_CFG  = 20'h00000,
    REG_PAD_OUT0  = 20'h00040,
    REG_PAD_OUT1  = 20'h00044,
    REG_PAD_OUT2  = 20'h00048,
    REG_PAD_OE0   = 20'h00050,
    REG_PAD_OE1   = 20'h00054,
    REG_PAD_OE2   = 20'h00058,
    REG_PAD_IN0   = 20'h00060,
    REG_PAD_IN1   = 20'h00064,
    REG_PAD_IN2   = 20'h00068,
    REG_EVENTS    = 20'h0006C,
    REG_TCDM_DATA = 20'h00080,
    REG_ID        = 20'h00800
  } reg_addr_e;

  localparam logic [11:0] DELAY_REGION = 12'h009; // addr 19:8 of the 0x9XX window
  localparam bus_data_t   ID_VALUE     = 32'hCA11EF3A;

endpackage

`default_nettype wire
